// File: source/replacer_cfg.svh
`ifndef REPLACER_CFG_SVH
`define REPLACER_CFG_SVH

// host word width in bits.
`define REPLACER_DATA_WIDTH 32

// entries in the PID table.
`define REPLACER_PID_SLOTS 4

// stored replacement packets, used round robin.
`define REPLACER_DATA_GROUPS 2

`endif

// File: source/ts_pkg.sv
package ts_pkg;

	// one byte of the transport stream.
	typedef logic [7:0] ts_byte_t;

	// packet identifier from the header.
	typedef logic [12:0] ts_pid_t;

	localparam ts_byte_t TS_SYNC_BYTE = 8'h47;

	localparam int TS_PKT_BYTES = 188;

	// four bytes per host word.
	localparam int TS_PKT_WORDS = TS_PKT_BYTES / 4;

	// output mode of the stream path.
	typedef enum logic {
		PASS,
		REPLACE
	} rep_state_t;

endpackage

// File: source/regs_pkg.sv
`include "replacer_cfg.svh"

package regs_pkg;

	import ts_pkg::*;

	// PID table entry as seen by the host.
	typedef struct packed {
		logic [14:0] pad1;
		logic enable;
		logic [2:0] pad0;
		ts_pid_t pid;
	} pid_entry_t;

	// replacement word, also read as byte lanes.
	// lane 0 is the first byte on the stream.
	typedef union packed {
		logic [`REPLACER_DATA_WIDTH-1:0] word;
		ts_byte_t [`REPLACER_DATA_WIDTH/8-1:0] lanes;
	} rep_word_u;

endpackage

// File: source/replace_if.sv
`timescale 1ns/1ns
`include "replacer_cfg.svh"

interface replace_if import ts_pkg::*; ();

	localparam int GROUP_W = (`REPLACER_DATA_GROUPS > 1) ? $clog2(`REPLACER_DATA_GROUPS) : 1;
	localparam int IDX_W = $clog2(TS_PKT_BYTES);

	logic replacing;
	logic [GROUP_W-1:0] group;
	logic [IDX_W-1:0] byte_idx;
	logic last;
	ts_byte_t rep_byte;

	modport fsm (output replacing, group, input byte_idx, last, rep_byte);

	modport counter (input replacing, output byte_idx, last);

	modport buffer (input group, byte_idx, output rep_byte);

endinterface

// File: source/pid_table.sv
`timescale 1ns/1ns
`include "replacer_cfg.svh"

module pid_table import regs_pkg::*, ts_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic pid_wr,
	input logic [`REPLACER_DATA_WIDTH-1:0] pid_index,
	input pid_entry_t pid_word,
	output pid_entry_t out_pid,
	input ts_pid_t hdr_pid,
	output logic hit
);

	localparam int SLOTS = `REPLACER_PID_SLOTS;
	localparam int IDX_W = $clog2(SLOTS);

	ts_pid_t slot_pid [SLOTS];
	logic [SLOTS-1:0] slot_en;
	logic [IDX_W-1:0] slot_sel;
	logic index_ok;

	assign slot_sel = pid_index[IDX_W-1:0];
	assign index_ok = (pid_index < SLOTS);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < SLOTS; i++) begin
				slot_pid[i] <= '0;
			end
			slot_en <= '0;
		end else if (pid_wr && index_ok) begin
			slot_pid[slot_sel] <= pid_word.pid;
			slot_en[slot_sel] <= pid_word.enable;
		end
	end

	// readback with pads forced to zero.
	always_comb begin
		out_pid = '0;
		if (index_ok) begin
			out_pid.enable = slot_en[slot_sel];
			out_pid.pid = slot_pid[slot_sel];
		end
	end

	// all slots compared in parallel.
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < SLOTS; i++) begin
			if (slot_en[i] && (slot_pid[i] == hdr_pid)) begin
				hit = 1'b1;
			end
		end
	end

endmodule

// File: source/replace_buffer.sv
`timescale 1ns/1ns
`include "replacer_cfg.svh"

module replace_buffer import regs_pkg::*, ts_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic data_wr,
	input logic [`REPLACER_DATA_WIDTH-1:0] data_index,
	input rep_word_u data_word,
	input logic dump_start,
	output logic dump_valid,
	output logic [`REPLACER_DATA_WIDTH-1:0] dump_index,
	output rep_word_u dump_word,
	output logic dump_done,
	replace_if.buffer rif
);

	localparam int DEPTH = TS_PKT_WORDS * `REPLACER_DATA_GROUPS;
	localparam int ADDR_W = $clog2(DEPTH);

	typedef enum logic {
		DUMP_IDLE,
		DUMP_RUN
	} dump_state_t;

	rep_word_u mem [DEPTH];
	dump_state_t dump_state;
	logic [ADDR_W-1:0] rd_addr;
	logic [ADDR_W-1:0] rep_addr;
	rep_word_u rep_word;
	logic dump_last;

	always_ff @(posedge clk) begin
		if (data_wr && (data_index < DEPTH)) begin
			mem[data_index[ADDR_W-1:0]] <= data_word;
		end
	end

	assign dump_last = (dump_index == DEPTH - 1);

	// address of the word shown in the next cycle.
	always_comb begin
		if ((dump_state == DUMP_IDLE) || dump_last) begin
			rd_addr = '0;
		end else begin
			rd_addr = ADDR_W'(dump_index + 1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dump_state <= DUMP_IDLE;
			dump_valid <= 1'b0;
			dump_done <= 1'b0;
			dump_index <= '0;
		end else begin
			dump_done <= 1'b0;
			case (dump_state)
				DUMP_IDLE: begin
					if (dump_start) begin
						dump_valid <= 1'b1;
						dump_index <= '0;
						dump_state <= DUMP_RUN;
					end
				end
				DUMP_RUN: begin
					if (dump_last) begin
						dump_valid <= 1'b0;
						dump_done <= 1'b1;
						dump_state <= DUMP_IDLE;
					end else begin
						dump_index <= dump_index + 1'b1;
					end
				end
				default: dump_state <= DUMP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		dump_word <= mem[rd_addr];
	end

	// word of the current group, then the lane within it.
	assign rep_addr = ADDR_W'(rif.group * TS_PKT_WORDS + (rif.byte_idx >> 2));
	assign rep_word = mem[rep_addr];
	assign rif.rep_byte = rep_word.lanes[rif.byte_idx[1:0]];

endmodule

// File: source/packet_byte_counter.sv
`timescale 1ns/1ns

module packet_byte_counter import ts_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ts_out_valid,
	replace_if.counter rif
);

	localparam int CNT_W = $clog2(TS_PKT_BYTES);

	// replaced bytes already sent before the one on the output.
	logic [CNT_W-1:0] cnt;
	// output register holds a replaced byte.
	logic active;
	logic [CNT_W-1:0] next_idx;

	always_comb begin
		if (ts_out_valid && active) begin
			next_idx = (cnt == CNT_W'(TS_PKT_BYTES - 1)) ? '0 : cnt + 1'b1;
		end else begin
			next_idx = cnt;
		end
	end

	assign rif.byte_idx = next_idx;
	assign rif.last = (next_idx == CNT_W'(TS_PKT_BYTES - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			active <= 1'b0;
		end else begin
			active <= rif.replacing;
			cnt <= rif.replacing ? next_idx : '0;
		end
	end

endmodule

// File: source/replace_fsm.sv
`timescale 1ns/1ns
`include "replacer_cfg.svh"

module replace_fsm import ts_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic match_enable,
	input logic bypass,
	input ts_byte_t ts_in,
	input logic ts_in_valid,
	input logic ts_in_sync,
	output ts_pid_t hdr_pid,
	input logic hit,
	output ts_byte_t ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync,
	output logic matched_state,
	replace_if.fsm rif
);

	ts_byte_t data_d1;
	ts_byte_t data_d2;
	ts_byte_t data_d3;
	logic [2:0] valid_d;
	logic [2:0] sync_d;
	rep_state_t state;
	logic hdr_seen;

	always_ff @(posedge clk) begin
		data_d1 <= ts_in;
		data_d2 <= data_d1;
		data_d3 <= data_d2;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_d <= '0;
			sync_d <= '0;
		end else begin
			valid_d <= {valid_d[1:0], ts_in_valid};
			sync_d <= {sync_d[1:0], ts_in_sync};
		end
	end

	// sync byte in stage two, PID bytes in stage one and on the input.
	assign hdr_seen = ts_in_valid && sync_d[1] && (data_d2 == TS_SYNC_BYTE);
	assign hdr_pid = {data_d1[4:0], ts_in};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= PASS;
			rif.group <= '0;
		end else if (bypass) begin
			state <= PASS;
		end else if (hdr_seen) begin
			if (hit && match_enable) begin
				state <= REPLACE;
				if (rif.group == (`REPLACER_DATA_GROUPS - 1)) begin
					rif.group <= '0;
				end else begin
					rif.group <= rif.group + 1'b1;
				end
			end else begin
				state <= PASS;
			end
		end else if ((state == REPLACE) && valid_d[2] && rif.last) begin
			// packet fully replaced.
			state <= PASS;
		end
	end

	assign rif.replacing = (state == REPLACE);
	assign matched_state = rif.replacing;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
		end else begin
			ts_out_valid <= valid_d[2];
			if (rif.replacing) begin
				ts_out_sync <= valid_d[2] && (rif.byte_idx == 0);
			end else begin
				ts_out_sync <= valid_d[2] && sync_d[2];
			end
		end
	end

	always_ff @(posedge clk) begin
		ts_out <= rif.replacing ? rif.rep_byte : data_d3;
	end

endmodule

// File: source/ts_replacer_top.sv
`timescale 1ns/1ns
`include "replacer_cfg.svh"

module ts_replacer_top import ts_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic match_enable,
	input logic bypass,
	input logic pid_wr,
	input logic [`REPLACER_DATA_WIDTH-1:0] pid_index,
	input logic [`REPLACER_DATA_WIDTH-1:0] pid_word,
	output logic [`REPLACER_DATA_WIDTH-1:0] out_pid,
	input logic data_wr,
	input logic [`REPLACER_DATA_WIDTH-1:0] data_index,
	input logic [`REPLACER_DATA_WIDTH-1:0] data_word,
	input logic dump_start,
	output logic dump_valid,
	output logic [`REPLACER_DATA_WIDTH-1:0] dump_index,
	output logic [`REPLACER_DATA_WIDTH-1:0] dump_word,
	output logic dump_done,
	input ts_byte_t ts_in,
	input logic ts_in_valid,
	input logic ts_in_sync,
	output ts_byte_t ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync,
	output logic matched_state
);

	ts_pid_t hdr_pid;
	logic hit;

	replace_if rif ();

	pid_table u_pid_table (
		.clk       (clk),
		.rst_n     (rst_n),
		.pid_wr    (pid_wr),
		.pid_index (pid_index),
		.pid_word  (pid_word),
		.out_pid   (out_pid),
		.hdr_pid   (hdr_pid),
		.hit       (hit)
	);

	replace_buffer u_replace_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.data_wr    (data_wr),
		.data_index (data_index),
		.data_word  (data_word),
		.dump_start (dump_start),
		.dump_valid (dump_valid),
		.dump_index (dump_index),
		.dump_word  (dump_word),
		.dump_done  (dump_done),
		.rif        (rif.buffer)
	);

	packet_byte_counter u_packet_byte_counter (
		.clk          (clk),
		.rst_n        (rst_n),
		.ts_out_valid (ts_out_valid),
		.rif          (rif.counter)
	);

	replace_fsm u_replace_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.match_enable  (match_enable),
		.bypass        (bypass),
		.ts_in         (ts_in),
		.ts_in_valid   (ts_in_valid),
		.ts_in_sync    (ts_in_sync),
		.hdr_pid       (hdr_pid),
		.hit           (hit),
		.ts_out        (ts_out),
		.ts_out_valid  (ts_out_valid),
		.ts_out_sync   (ts_out_sync),
		.matched_state (matched_state),
		.rif           (rif.fsm)
	);

endmodule

// File: sim/replacer_checker.sv
`timescale 1ns/1ns
`include "replacer_cfg.svh"

module replacer_checker import ts_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic match_enable,
	input logic bypass,
	input logic pid_wr,
	input logic [31:0] pid_index,
	input logic [31:0] pid_word,
	input logic [31:0] out_pid,
	input logic data_wr,
	input logic [31:0] data_index,
	input logic [31:0] data_word,
	input logic dump_start,
	input logic dump_valid,
	input logic [31:0] dump_index,
	input logic [31:0] dump_word,
	input logic dump_done,
	input logic [7:0] ts_in,
	input logic ts_in_valid,
	input logic ts_in_sync,
	input logic [7:0] ts_out,
	input logic ts_out_valid,
	input logic ts_out_sync,
	input logic matched_state,
	input int test_id,
	input logic test_done,
	input logic rb_check,
	input logic [31:0] rb_expect,
	input logic run_done,
	output int error_total
);

	localparam int SLOTS = `REPLACER_PID_SLOTS;
	localparam int GROUPS = `REPLACER_DATA_GROUPS;
	localparam int DEPTH = TS_PKT_WORDS * GROUPS;

	logic [12:0] pid_model [SLOTS];
	logic [SLOTS-1:0] en_model;
	logic [31:0] mem_model [DEPTH];

	// input bytes still inside the delay line.
	logic [7:0] byte_q[$];
	logic sync_q[$];
	int pos_q[$];
	int pkt_q[$];
	// decision per packet, filled in at header byte 2.
	bit pkt_rep[$];
	int pkt_grp[$];

	int in_pos = TS_PKT_BYTES;
	int pkt_num = -1;
	int group_model = 0;
	logic [4:0] pid_hi;
	logic [3:0] vhist;
	int dump_phase = 0;
	bit after_reset = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	initial error_total = 0;

	function automatic string test_name(input int id);
		case (id)
			0: return "reset_and_readback";
			1: return "fill_and_dump";
			2: return "pass_through";
			3: return "single_replace";
			4: return "round_robin";
			default: return "unnamed";
		endcase
	endfunction

	function automatic logic [31:0] expected_readback(input logic [31:0] idx);
		logic [31:0] w;
		w = '0;
		if (idx < SLOTS) begin
			w[16] = en_model[idx];
			w[12:0] = pid_model[idx];
		end
		return w;
	endfunction

	function automatic bit table_hit(input logic [12:0] pid);
		bit h;
		h = 0;
		for (int i = 0; i < SLOTS; i++) begin
			if (en_model[i] && pid_model[i] == pid) begin
				h = 1;
			end
		end
		return h;
	endfunction

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("MISMATCH %s %s: expected %h actual %h", test_name(test_id), what, exp, act);
		test_errors++;
		error_total++;
	endtask

	task automatic fault(input string msg);
		$display("ERROR %s: %s", test_name(test_id), msg);
		test_errors++;
		error_total++;
	endtask

	task automatic stream_compare();
		logic [7:0] b;
		logic s;
		int p;
		int k;
		bit rep;
		int g;
		logic [7:0] exp_b;
		logic exp_s;
		logic exp_m;
		if (ts_out_valid !== vhist[3]) begin
			mismatch("ts_out_valid", vhist[3], ts_out_valid);
		end
		if (ts_out_valid === 1'b1) begin
			if (byte_q.size() == 0) begin
				fault("output byte appeared with no input byte pending");
			end else begin
				b = byte_q.pop_front();
				s = sync_q.pop_front();
				p = pos_q.pop_front();
				k = pkt_q.pop_front();
				rep = (k >= 0) ? pkt_rep[k] : 0;
				g = (k >= 0) ? pkt_grp[k] : 0;
				if (rep) begin
					exp_b = 8'(mem_model[g * TS_PKT_WORDS + p / 4] >> (8 * (p % 4)));
					exp_s = (p == 0);
				end else begin
					exp_b = b;
					exp_s = s;
				end
				if (ts_out !== exp_b) begin
					mismatch($sformatf("ts_out byte %0d", p), exp_b, ts_out);
				end
				if (ts_out_sync !== exp_s) begin
					mismatch($sformatf("ts_out_sync byte %0d", p), exp_s, ts_out_sync);
				end
				// state drops to pass while the last byte loads.
				exp_m = rep && (p < TS_PKT_BYTES - 1);
				if (matched_state !== exp_m) begin
					mismatch($sformatf("matched_state byte %0d", p), exp_m, matched_state);
				end
			end
		end
		vhist = {vhist[2:0], ts_in_valid};
		if (ts_in_valid === 1'b1) begin
			if (ts_in_sync && ts_in == TS_SYNC_BYTE) begin
				in_pos = 0;
				pkt_num++;
				pkt_rep.push_back(0);
				pkt_grp.push_back(0);
			end
			if (in_pos == 1) begin
				pid_hi = ts_in[4:0];
			end
			if (in_pos == 2 && !bypass && match_enable && table_hit({pid_hi, ts_in})) begin
				group_model = (group_model + 1) % GROUPS;
				pkt_rep[pkt_num] = 1;
				pkt_grp[pkt_num] = group_model;
			end
			byte_q.push_back(ts_in);
			sync_q.push_back(ts_in_sync);
			pos_q.push_back(in_pos);
			pkt_q.push_back((in_pos < TS_PKT_BYTES) ? pkt_num : -1);
			if (in_pos < TS_PKT_BYTES) begin
				in_pos++;
			end
		end
	endtask

	task automatic dump_compare();
		if (dump_phase == 0) begin
			if (dump_valid !== 1'b0) begin
				mismatch("dump_valid idle", 0, dump_valid);
			end
			if (dump_done !== 1'b0) begin
				mismatch("dump_done idle", 0, dump_done);
			end
		end else if (dump_phase <= DEPTH) begin
			if (dump_valid !== 1'b1) begin
				mismatch("dump_valid", 1, dump_valid);
			end else begin
				if (dump_index !== dump_phase - 1) begin
					mismatch("dump_index", dump_phase - 1, dump_index);
				end
				if (dump_word !== mem_model[dump_phase - 1]) begin
					mismatch($sformatf("dump_word %0d", dump_phase - 1),
						mem_model[dump_phase - 1], dump_word);
				end
			end
			if (dump_done !== 1'b0) begin
				mismatch("dump_done early", 0, dump_done);
			end
			dump_phase++;
		end else begin
			if (dump_done !== 1'b1) begin
				mismatch("dump_done", 1, dump_done);
			end
			if (dump_valid !== 1'b0) begin
				mismatch("dump_valid after run", 0, dump_valid);
			end
			dump_phase = 0;
		end
		if (dump_start && dump_phase == 0) begin
			dump_phase = 1;
		end
	endtask

	task automatic host_compare();
		if (rb_check && out_pid !== rb_expect) begin
			mismatch($sformatf("pid readback slot %0d", pid_index), rb_expect, out_pid);
		end
		if (out_pid !== expected_readback(pid_index)) begin
			mismatch("pid readback model", expected_readback(pid_index), out_pid);
		end
		// writes land on the next edge.
		if (pid_wr && pid_index < SLOTS) begin
			pid_model[pid_index] = pid_word[12:0];
			en_model[pid_index] = pid_word[16];
		end
		if (data_wr && data_index < DEPTH) begin
			mem_model[data_index] = data_word;
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			vhist = '0;
			dump_phase = 0;
			in_pos = TS_PKT_BYTES;
			en_model = '0;
			for (int i = 0; i < SLOTS; i++) begin
				pid_model[i] = '0;
			end
			after_reset = 1;
		end else begin
			if (after_reset) begin
				if ({ts_out_valid, ts_out_sync, matched_state, dump_valid, dump_done} !== 5'b0) begin
					fault("outputs not cleared after reset");
				end
				after_reset = 0;
			end
			stream_compare();
			dump_compare();
			host_compare();
		end
		if (test_done) begin
			tests_run++;
			if (test_errors != 0) begin
				tests_failed++;
			end
			$display("test %0d %s: %s (%0d errors)", test_id, test_name(test_id),
				(test_errors == 0) ? "ok" : "failed", test_errors);
			test_errors = 0;
		end
		if (run_done) begin
			$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
				error_total);
		end
	end

endmodule

// File: sim/tb_replacer.sv
`timescale 1ns/1ns

module tb_replacer import ts_pkg::*; ();

	localparam int SEED = 32'h54e3_c6e4;

	logic clk;
	logic rst_n;
	logic match_enable;
	logic bypass;
	logic pid_wr;
	logic [31:0] pid_index;
	logic [31:0] pid_word;
	logic [31:0] out_pid;
	logic data_wr;
	logic [31:0] data_index;
	logic [31:0] data_word;
	logic dump_start;
	logic dump_valid;
	logic [31:0] dump_index;
	logic [31:0] dump_word;
	logic dump_done;
	logic [7:0] ts_in;
	logic ts_in_valid;
	logic ts_in_sync;
	logic [7:0] ts_out;
	logic ts_out_valid;
	logic ts_out_sync;
	logic matched_state;

	int test_id;
	logic test_done;
	logic rb_check;
	logic [31:0] rb_expect;
	logic run_done;
	int error_total;

	string lines[$];
	int limit_cycles;
	bit limit_ready = 0;

	ts_replacer_top UUT (.*);

	replacer_checker u_checker (.*);

	always #50 clk = ~clk;

	// fill word mixes the full address into every lane.
	function automatic logic [31:0] fill_word(input int addr, input logic [31:0] seed);
		return seed ^ (addr * 32'h0103_0507) ^ {8'(addr), 24'h0};
	endfunction

	task automatic write_pid(input int idx, input logic [31:0] word);
		@(posedge clk);
		pid_wr <= 1'b1;
		pid_index <= idx;
		pid_word <= word;
		@(posedge clk);
		pid_wr <= 1'b0;
	endtask

	task automatic expect_readback(input int idx, input logic [31:0] word);
		@(posedge clk);
		pid_index <= idx;
		rb_expect <= word;
		rb_check <= 1'b1;
		@(posedge clk);
		rb_check <= 1'b0;
	endtask

	task automatic fill_group(input int g, input logic [31:0] seed);
		int addr;
		for (int w = 0; w < TS_PKT_WORDS; w++) begin
			addr = g * TS_PKT_WORDS + w;
			@(posedge clk);
			data_wr <= 1'b1;
			data_index <= addr;
			data_word <= fill_word(addr, seed);
		end
		@(posedge clk);
		data_wr <= 1'b0;
	endtask

	task automatic run_dump();
		int n;
		n = 0;
		@(posedge clk);
		dump_start <= 1'b1;
		@(posedge clk);
		dump_start <= 1'b0;
		while (dump_done !== 1'b1 && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (dump_done !== 1'b1) begin
			$display("dump_done never arrived within 200 cycles of dump_start");
			$display("TEST FAIL");
			$finish;
		end else begin
			@(posedge clk);
		end
	endtask

	task automatic send_packets(input int pid, input int count, input int me, input int bp);
		int gap;
		// let the previous packet leave the delay line first.
		repeat (6) @(posedge clk);
		match_enable <= me[0];
		bypass <= bp[0];
		for (int n = 0; n < count; n++) begin
			gap = 4 + ($urandom % 8);
			repeat (gap) @(posedge clk);
			for (int i = 0; i < TS_PKT_BYTES; i++) begin
				@(posedge clk);
				ts_in_valid <= 1'b1;
				ts_in_sync <= (i == 0);
				if (i == 0) begin
					ts_in <= TS_SYNC_BYTE;
				end else if (i == 1) begin
					ts_in <= {3'($urandom), pid[12:8]};
				end else if (i == 2) begin
					ts_in <= pid[7:0];
				end else begin
					ts_in <= 8'($urandom);
				end
			end
			@(posedge clk);
			ts_in_valid <= 1'b0;
			ts_in_sync <= 1'b0;
		end
	endtask

	task automatic end_test();
		repeat (8) @(posedge clk);
		test_done <= 1'b1;
		@(posedge clk);
		test_done <= 1'b0;
	endtask

	initial begin
		int fd;
		string line_s;
		int a;
		int b;
		int c;
		int d;
		int bytes;
		clk = 1'b0;
		rst_n = 1'b0;
		match_enable = 1'b0;
		bypass = 1'b0;
		pid_wr = 1'b0;
		pid_index = '0;
		pid_word = '0;
		data_wr = 1'b0;
		data_index = '0;
		data_word = '0;
		dump_start = 1'b0;
		ts_in = '0;
		ts_in_valid = 1'b0;
		ts_in_sync = 1'b0;
		test_id = 0;
		test_done = 1'b0;
		rb_check = 1'b0;
		rb_expect = '0;
		run_done = 1'b0;
		void'($urandom(SEED));

		fd = $fopen("sim/replacer_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/replacer_vectors.txt");
			$display("TEST FAIL");
			$finish;
		end
		while (!$feof(fd)) begin
			if ($fgets(line_s, fd) > 0) begin
				if (line_s.len() > 1 && line_s[0] != "#") begin
					lines.push_back(line_s);
				end
			end
		end
		$fclose(fd);

		// run length from the packet lines.
		bytes = 0;
		foreach (lines[i]) begin
			if (lines[i][0] == "K" && $sscanf(lines[i], "K %h %d %d %d", a, b, c, d) == 4) begin
				bytes += b * TS_PKT_BYTES;
			end
		end
		limit_cycles = bytes * 4 + 5000;
		limit_ready = 1;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		foreach (lines[i]) begin
			line_s = lines[i];
			case (line_s[0])
				"T": if ($sscanf(line_s, "T %d", a) == 1) test_id <= a;
				"E": end_test();
				"P": if ($sscanf(line_s, "P %d %h", a, b) == 2) write_pid(a, b);
				"R": if ($sscanf(line_s, "R %d %h", a, b) == 2) expect_readback(a, b);
				"F": if ($sscanf(line_s, "F %d %h", a, b) == 2) fill_group(a, b);
				"D": run_dump();
				"K": begin
					if ($sscanf(line_s, "K %h %d %d %d", a, b, c, d) == 4) begin
						send_packets(a, b, c, d);
					end
				end
				default: $display("skipping unknown vector line: %s", line_s);
			endcase
		end

		repeat (4) @(posedge clk);
		run_done <= 1'b1;
		@(posedge clk);
		run_done <= 1'b0;
		if (error_total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		wait (limit_ready);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, stimulus did not finish", limit_cycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: sim/replacer_vectors.txt
# T id starts a test, E ends it, P slot word writes a PID entry, R slot word expects readback
# F group seed fills a group, D dumps, K pid count match_enable bypass sends packets
T 0
P 0 ffff0100
P 1 00011abc
P 2 fffe0055
P 7 00010200
R 0 00010100
R 1 00011abc
R 2 00000055
R 3 00000000
E
T 1
F 0 a5000000
F 1 3c000000
D
E
T 2
K 0200 2 1 0
K 0055 1 1 0
K 0100 1 0 0
K 1abc 1 1 1
E
T 3
K 0100 1 1 0
E
T 4
K 1abc 2 1 0
K 0200 1 1 0
K 0100 3 1 0
E

// File: sim.f
+incdir+source
source/ts_pkg.sv
source/regs_pkg.sv
source/replace_if.sv
source/pid_table.sv
source/replace_buffer.sv
source/packet_byte_counter.sv
source/replace_fsm.sv
source/ts_replacer_top.sv
sim/replacer_checker.sv
sim/tb_replacer.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_replacer
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
